// File: compile.f
hw/quad_servo_pkg.sv
hw/leg_cmd_if.sv
hw/servo_pwm.sv
hw/leg_ctrl.sv
hw/gait_status.sv
hw/quad_servo_top.sv
test/tb_quad_servo.sv

// File: hw/gait_status.sv
module gait_status
#(
  parameter int FIFO_DEPTH = 16,                  // sets the fill width
  parameter int PG_FULL    = 12                   // nearly full threshold
)
(
  input  logic                            clk_72m,
  input  logic                            rst,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fill_0, // foot 0 queue level
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fill_1,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fill_2,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] fill_3,
  output logic                            foot_backpress,   // any queue nearly full
  output logic                            foot_busystate    // any queue holds work
);

  logic any_full;
  logic any_busy;

  //*********************************************************************
  // combine the four levels
  //*********************************************************************
  always_comb
  begin
    any_full = (fill_0 >= PG_FULL) || (fill_1 >= PG_FULL) ||
               (fill_2 >= PG_FULL) || (fill_3 >= PG_FULL);
    any_busy = (fill_0 != '0) || (fill_1 != '0) ||
               (fill_2 != '0) || (fill_3 != '0);
  end

  always_ff @(posedge clk_72m)
  begin
    if (rst)
    begin
      foot_backpress <= 1'b0;
      foot_busystate <= 1'b0;
    end
    else
    begin
      foot_backpress <= any_full;                 // one cycle behind fill
      foot_busystate <= any_busy;
    end
  end

  // every queue drained means idle on the next edge
  a_idle : assert property (@(posedge clk_72m) disable iff (rst)
    ((fill_0 == '0) && (fill_1 == '0) && (fill_2 == '0) && (fill_3 == '0))
    |=> !foot_busystate);

endmodule

// File: hw/leg_cmd_if.sv
interface leg_cmd_if;

  logic                   vld;                    // one cycle command strobe
  quad_servo_pkg::foot_t  foot;                   // target foot
  quad_servo_pkg::width_t width_a;                // joint a width
  quad_servo_pkg::width_t width_b;                // joint b width
  quad_servo_pkg::width_t width_c;                // joint c width

  // top level drives the shared command
  modport src
  (
    output vld, foot, width_a, width_b, width_c
  );

  // every leg sees the same command, filters by foot
  modport leg
  (
    input  vld, foot, width_a, width_b, width_c
  );

endinterface

// File: hw/leg_ctrl.sv
module leg_ctrl
#(
  parameter quad_servo_pkg::foot_t FOOT_ID      = '0,       // foot this leg answers to
  parameter int                    FRAME_CYCLES = 1440000,
  parameter int                    FIFO_DEPTH   = 16,
  parameter quad_servo_pkg::bias_t BIAS_A       = '0,
  parameter quad_servo_pkg::bias_t BIAS_B       = '0,
  parameter quad_servo_pkg::bias_t BIAS_C       = '0
)
(
  input  logic                              clk_72m,
  input  logic                              rst,
  leg_cmd_if.leg                            cmd,      // shared command bus
  output logic [2:0]                        servo,    // joint a b c pwm
  output logic [$clog2(FIFO_DEPTH+1)-1:0]   fill      // queued commands
);

  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

  logic [47:0]              mem [FIFO_DEPTH];     // {a, b, c} per entry
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic                     accept;               // command is for this foot
  logic                     wr_en;
  logic                     rd_en;
  logic                     frame_end;            // from the pwm timer
  logic                     armed;                // first command has played
  logic [2:0]               pwm_servo;
  quad_servo_pkg::width_t   width_a;              // widths of the current frame
  quad_servo_pkg::width_t   width_b;
  quad_servo_pkg::width_t   width_c;

  //*********************************************************************
  // queue control
  //*********************************************************************
  assign accept = cmd.vld && (cmd.foot == FOOT_ID);
  assign wr_en  = accept && (fill != FILL_W'(FIFO_DEPTH));    // full drops it
  assign rd_en  = frame_end && (fill != '0);                  // one pop per frame

  always_ff @(posedge clk_72m)
  begin
    if (wr_en)
      mem[wr_ptr] <= {cmd.width_a, cmd.width_b, cmd.width_c};
  end

  always_ff @(posedge clk_72m)
  begin
    if (rst)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      armed   <= 1'b0;
      width_a <= '0;
      width_b <= '0;
      width_c <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
      begin
        rd_ptr                      <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        {width_a, width_b, width_c} <= mem[rd_ptr];     // live from next frame
        armed                       <= 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;                          // idle or push and pop
      endcase
    end
  end

  //*********************************************************************
  // pulse generator
  //*********************************************************************
  servo_pwm
  #(
    .FRAME_CYCLES   (FRAME_CYCLES   ),
    .BIAS_A         (BIAS_A         ),
    .BIAS_B         (BIAS_B         ),
    .BIAS_C         (BIAS_C         )
  )
  servo_pwm_inst
  (
    .clk_72m        (clk_72m        ),  // input
    .rst            (rst            ),  // input
    .width_a        (width_a        ),  // input  [15:0]
    .width_b        (width_b        ),  // input  [15:0]
    .width_c        (width_c        ),  // input  [15:0]
    .servo          (pwm_servo      ),  // output [2:0]
    .frame_end      (frame_end      )   // output
  );

  // bias alone would pulse a positive trim joint, so stay quiet until armed
  assign servo = pwm_servo & {3{armed}};

  a_fill_max  : assert property (@(posedge clk_72m) disable iff (rst)
    fill <= FIFO_DEPTH);

  a_full_hold : assert property (@(posedge clk_72m) disable iff (rst)
    (fill == FILL_W'(FIFO_DEPTH)) |=> (fill <= $past(fill)));

endmodule

// File: hw/quad_servo_pkg.sv
package quad_servo_pkg;

  //*********************************************************************
  // shared widths and types
  //*********************************************************************
  localparam int NUM_FEET   = 4;                  // legs on the robot
  localparam int NUM_JOINTS = 3;                  // servos per leg, a b c

  typedef logic        [15:0] width_t;            // pulse width in clk ticks
  typedef logic signed [15:0] bias_t;             // signed trim in clk ticks
  typedef logic        [1:0]  foot_t;             // foot number 0..3

  // flat bias table, index = foot * NUM_JOINTS + joint
  typedef bias_t bias_arr_t [NUM_FEET*NUM_JOINTS];

  //*********************************************************************
  // default joint trims per foot
  //*********************************************************************
  localparam bias_arr_t DEFAULT_BIAS = '{
    bias_t'(70),                                  // foot 0 joint a
    bias_t'(-25),                                 // foot 0 joint b
    bias_t'(-10),                                 // foot 0 joint c
    bias_t'(-110),                                // foot 1 joint a
    bias_t'(-40),                                 // foot 1 joint b
    bias_t'(-75),                                 // foot 1 joint c
    bias_t'(-75),                                 // foot 2 joint a
    bias_t'(-20),                                 // foot 2 joint b
    bias_t'(-35),                                 // foot 2 joint c
    bias_t'(-5),                                  // foot 3 joint a
    bias_t'(-55),                                 // foot 3 joint b
    bias_t'(-45)                                  // foot 3 joint c
  };

endpackage

// File: hw/quad_servo_top.sv
module quad_servo_top
#(
  parameter int                        FRAME_CYCLES = 1440000,   // 20 ms frame
  parameter int                        FIFO_DEPTH   = 16,
  parameter int                        PG_FULL      = 12,
  parameter quad_servo_pkg::bias_arr_t BIAS         = quad_servo_pkg::DEFAULT_BIAS
)
(
  input  logic                   clk_72m,
  input  logic                   rst,
  input  logic                   cmd_vld,         // single cycle strobe
  input  quad_servo_pkg::foot_t  cmd_foot,
  input  quad_servo_pkg::width_t cmd_width_a,
  input  quad_servo_pkg::width_t cmd_width_b,
  input  quad_servo_pkg::width_t cmd_width_c,
  output logic servo_1a, output logic servo_1b, output logic servo_1c,
  output logic servo_2a, output logic servo_2b, output logic servo_2c,
  output logic servo_3a, output logic servo_3b, output logic servo_3c,
  output logic servo_4a, output logic servo_4b, output logic servo_4c,
  output logic                   foot_backpress,  // advisory only
  output logic                   foot_busystate
);

  localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

  logic [2:0]        leg_servo [quad_servo_pkg::NUM_FEET];  // per foot, bit 0 = joint a
  logic [FILL_W-1:0] leg_fill  [quad_servo_pkg::NUM_FEET];

  //*********************************************************************
  // command bus
  //*********************************************************************
  leg_cmd_if cmd_bus();

  assign cmd_bus.vld     = cmd_vld;
  assign cmd_bus.foot    = cmd_foot;
  assign cmd_bus.width_a = cmd_width_a;
  assign cmd_bus.width_b = cmd_width_b;
  assign cmd_bus.width_c = cmd_width_c;

  //*********************************************************************
  // four legs side by side
  //*********************************************************************
  for (genvar f = 0; f < quad_servo_pkg::NUM_FEET; f++)
  begin : g_leg
    leg_ctrl
    #(
      .FOOT_ID      (quad_servo_pkg::foot_t'(f)                    ),
      .FRAME_CYCLES (FRAME_CYCLES                                  ),
      .FIFO_DEPTH   (FIFO_DEPTH                                    ),
      .BIAS_A       (BIAS[f*quad_servo_pkg::NUM_JOINTS + 0]        ),
      .BIAS_B       (BIAS[f*quad_servo_pkg::NUM_JOINTS + 1]        ),
      .BIAS_C       (BIAS[f*quad_servo_pkg::NUM_JOINTS + 2]        )
    )
    leg_ctrl_inst
    (
      .clk_72m      (clk_72m       ),   // input
      .rst          (rst           ),   // input
      .cmd          (cmd_bus.leg   ),   // shared command
      .servo        (leg_servo[f]  ),   // output [2:0]
      .fill         (leg_fill[f]   )    // output queue level
    );
  end

  assign {servo_1c, servo_1b, servo_1a} = leg_servo[0];
  assign {servo_2c, servo_2b, servo_2a} = leg_servo[1];
  assign {servo_3c, servo_3b, servo_3a} = leg_servo[2];
  assign {servo_4c, servo_4b, servo_4a} = leg_servo[3];

  gait_status
  #(
    .FIFO_DEPTH     (FIFO_DEPTH     ),
    .PG_FULL        (PG_FULL        )
  )
  gait_status_inst
  (
    .clk_72m        (clk_72m        ),  // input
    .rst            (rst            ),  // input
    .fill_0         (leg_fill[0]    ),
    .fill_1         (leg_fill[1]    ),
    .fill_2         (leg_fill[2]    ),
    .fill_3         (leg_fill[3]    ),
    .foot_backpress (foot_backpress ),  // output reg
    .foot_busystate (foot_busystate )   // output reg
  );

endmodule

// File: hw/servo_pwm.sv
module servo_pwm
#(
  parameter int                    FRAME_CYCLES = 1440000,  // 20 ms at 72 MHz
  parameter quad_servo_pkg::bias_t BIAS_A       = '0,
  parameter quad_servo_pkg::bias_t BIAS_B       = '0,
  parameter quad_servo_pkg::bias_t BIAS_C       = '0
)
(
  input  logic                   clk_72m,
  input  logic                   rst,
  input  quad_servo_pkg::width_t width_a,         // commanded width joint a
  input  quad_servo_pkg::width_t width_b,
  input  quad_servo_pkg::width_t width_c,
  output logic [2:0]             servo,           // registered pwm, bit 0 = joint a
  output logic                   frame_end        // last cycle of the frame
);

  localparam int CNT_W = $clog2(FRAME_CYCLES);

  logic [CNT_W-1:0] frame_cnt;                    // position inside the frame
  logic [CNT_W-1:0] eff_w [3];                    // clamped width plus bias

  // width plus trim, held inside 0 .. FRAME_CYCLES-1
  function automatic logic [CNT_W-1:0] clamp_width
  (
    input quad_servo_pkg::width_t w,
    input quad_servo_pkg::bias_t  b
  );
    logic signed [31:0] sum;
    sum = $signed({16'd0, w}) + 32'(b);           // trim sign extends
    if (sum < 0)
      clamp_width = '0;                           // negative means never high
    else if (sum > FRAME_CYCLES - 1)
      clamp_width = CNT_W'(FRAME_CYCLES - 1);     // keep one low cycle per frame
    else
      clamp_width = sum[CNT_W-1:0];
  endfunction

  //*********************************************************************
  // frame timer
  //*********************************************************************
  assign frame_end = (frame_cnt == CNT_W'(FRAME_CYCLES - 1));

  always_comb
  begin
    eff_w[0] = clamp_width(width_a, BIAS_A);
    eff_w[1] = clamp_width(width_b, BIAS_B);
    eff_w[2] = clamp_width(width_c, BIAS_C);
  end

  //*********************************************************************
  // counter and pulse compare
  //*********************************************************************
  always_ff @(posedge clk_72m)
  begin
    if (rst)
    begin
      frame_cnt <= '0;
      servo     <= '0;
    end
    else
    begin
      frame_cnt <= frame_end ? '0 : frame_cnt + 1'b1;   // wrap at frame end
      for (int j = 0; j < 3; j++)
        servo[j] <= (frame_cnt < eff_w[j]);             // high for eff_w cycles
    end
  end

  // counter wraps before reaching the frame length
  a_cnt_range : assert property (@(posedge clk_72m) disable iff (rst)
    frame_cnt < FRAME_CYCLES);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the quad servo testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_quad_servo -f compile.f -o sim_quad_servo

# the result is taken from the log, so a failing run does not stop the script here
./obj_dir/sim_quad_servo 2>&1 | tee sim.log || true

if grep -qx "all tests passed" sim.log; then
  echo "simulation PASSED"
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi

// File: test/tb_quad_servo.sv
module tb_quad_servo;

  localparam int FRAME_CYCLES   = 64;
  localparam int FIFO_DEPTH     = 8;
  localparam int PG_FULL        = 6;
  localparam int NUM_OUT        = 12;               // four feet of three joints
  localparam int TIMEOUT_CYCLES = 5000;             // about twice the test length

  // reference joint trims, index = foot * 3 + joint
  localparam int TRIM [NUM_OUT] = '{70, -25, -10, -110, -40, -75,
                                    -75, -20, -35, -5, -55, -45};

  logic                   clk_72m;
  logic                   rst;
  logic                   cmd_vld;
  quad_servo_pkg::foot_t  cmd_foot;
  quad_servo_pkg::width_t cmd_width_a;
  quad_servo_pkg::width_t cmd_width_b;
  quad_servo_pkg::width_t cmd_width_c;
  logic servo_1a, servo_1b, servo_1c, servo_2a, servo_2b, servo_2c;
  logic servo_3a, servo_3b, servo_3c, servo_4a, servo_4b, servo_4c;
  logic                   foot_backpress;
  logic                   foot_busystate;
  logic [NUM_OUT-1:0]     svo;                      // bit = foot * 3 + joint

  logic [47:0]            mq [quad_servo_pkg::NUM_FEET][$];  // expected queue per foot
  logic [15:0]            cur_w [NUM_OUT];          // widths playing now
  logic                   armed [quad_servo_pkg::NUM_FEET];
  int                     acc [NUM_OUT];            // high cycles this frame
  int                     exp_frame [NUM_OUT];      // expected high cycles this frame
  int                     meas [NUM_OUT];           // finished frame, measured
  int                     exp_hi [NUM_OUT];         // finished frame, expected
  logic                   meas_vld;
  logic                   busy_d;
  logic                   bp_d;
  logic                   bp_seen;
  logic                   started;
  int                     cnt_m;                    // copy of the frame counter
  int                     cycle_cnt;
  int                     seed;

  assign svo = {servo_4c, servo_4b, servo_4a, servo_3c, servo_3b, servo_3a,
                servo_2c, servo_2b, servo_2a, servo_1c, servo_1b, servo_1a};

  quad_servo_top
  #(
    .FRAME_CYCLES   (FRAME_CYCLES   ),
    .FIFO_DEPTH     (FIFO_DEPTH     ),
    .PG_FULL        (PG_FULL        )
  )
  i_quad_servo_top
  (
    .clk_72m        (clk_72m        ),
    .rst            (rst            ),
    .cmd_vld        (cmd_vld        ),
    .cmd_foot       (cmd_foot       ),
    .cmd_width_a    (cmd_width_a    ),
    .cmd_width_b    (cmd_width_b    ),
    .cmd_width_c    (cmd_width_c    ),
    .servo_1a       (servo_1a       ), .servo_1b (servo_1b), .servo_1c (servo_1c),
    .servo_2a       (servo_2a       ), .servo_2b (servo_2b), .servo_2c (servo_2c),
    .servo_3a       (servo_3a       ), .servo_3b (servo_3b), .servo_3c (servo_3c),
    .servo_4a       (servo_4a       ), .servo_4b (servo_4b), .servo_4c (servo_4c),
    .foot_backpress (foot_backpress ),
    .foot_busystate (foot_busystate )
  );

  always #50 clk_72m = ~clk_72m;                    // period 100

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // commanded width plus trim, kept inside one frame
  function automatic int expected_high(input logic [15:0] w, input int b);
    int e;
    e = int'(w) + b;
    if (e < 0)
      return 0;
    if (e > FRAME_CYCLES - 1)
      return FRAME_CYCLES - 1;
    return e;
  endfunction

  function automatic string servo_name(input int i);
    return $sformatf("servo_%0d%c", i / 3 + 1, 8'(97 + i % 3));
  endfunction

  //**********************************************************************
  // reference model, sampled on the rising edge
  //**********************************************************************
  always @(posedge clk_72m)
  begin
    logic [47:0] head;
    logic        full;
    if (rst)
    begin
      for (int f = 0; f < quad_servo_pkg::NUM_FEET; f++)
      begin
        mq[f].delete();
        armed[f] = 1'b0;
      end
      for (int i = 0; i < NUM_OUT; i++)
      begin
        cur_w[i]     = '0;
        acc[i]       = 0;
        exp_frame[i] = 0;
      end
      cnt_m    = 0;
      started  = 1'b0;
      bp_seen  = 1'b0;
      meas_vld <= 1'b0;
      busy_d   <= 1'b0;
      bp_d     <= 1'b0;
    end
    else
    begin
      busy_d <= (mq[0].size() != 0) || (mq[1].size() != 0) ||
                (mq[2].size() != 0) || (mq[3].size() != 0);   // flag lags fill by one
      bp_d   <= (mq[0].size() >= PG_FULL) || (mq[1].size() >= PG_FULL) ||
                (mq[2].size() >= PG_FULL) || (mq[3].size() >= PG_FULL);
      if (foot_backpress)
        bp_seen = 1'b1;
      for (int i = 0; i < NUM_OUT; i++)
        acc[i] += int'(svo[i]);                     // sample is one count behind
      meas_vld <= 1'b0;
      if (cnt_m == 0)
      begin
        for (int i = 0; i < NUM_OUT; i++)
        begin
          meas[i]      <= acc[i];                   // previous frame is complete
          exp_hi[i]    <= exp_frame[i];
          acc[i]       = 0;
          exp_frame[i] = armed[i / 3] ? expected_high(cur_w[i], TRIM[i]) : 0;
        end
        meas_vld <= started;                        // nothing to check before frame 0
        started  = 1'b1;
      end
      full = (mq[cmd_foot].size() >= FIFO_DEPTH);   // full before this edge's pop
      if (cnt_m == FRAME_CYCLES - 1)
      begin
        for (int f = 0; f < quad_servo_pkg::NUM_FEET; f++)
        begin
          if (mq[f].size() != 0)
          begin
            head           = mq[f].pop_front();     // one entry per frame
            cur_w[f*3 + 0] = head[47:32];
            cur_w[f*3 + 1] = head[31:16];
            cur_w[f*3 + 2] = head[15:0];
            armed[f]       = 1'b1;
          end
        end
      end
      if (cmd_vld && !full)
        mq[cmd_foot].push_back({cmd_width_a, cmd_width_b, cmd_width_c});
      cnt_m = (cnt_m == FRAME_CYCLES - 1) ? 0 : cnt_m + 1;
    end
  end

  //**********************************************************************
  // checks
  //**********************************************************************
  for (genvar i = 0; i < NUM_OUT; i++)
  begin : g_chk
    a_width : assert property (@(posedge clk_72m) disable iff (rst)
      meas_vld |-> (meas[i] == exp_hi[i]))
      else stop_on_error($sformatf("[FAIL] t=%0t %s high cycles expected %0d actual %0d",
                                   $time, servo_name(i), exp_hi[i], meas[i]));
  end

  a_busy : assert property (@(posedge clk_72m) disable iff (rst)
    foot_busystate == busy_d)
    else stop_on_error($sformatf("[FAIL] t=%0t foot_busystate expected %0b actual %0b",
                                 $time, busy_d, foot_busystate));

  a_backpress : assert property (@(posedge clk_72m) disable iff (rst)
    foot_backpress == bp_d)
    else stop_on_error($sformatf("[FAIL] t=%0t foot_backpress expected %0b actual %0b",
                                 $time, bp_d, foot_backpress));

  always @(posedge clk_72m)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_on_error("timeout, the run went past its cycle limit");
  end

  //**********************************************************************
  // stimulus
  //**********************************************************************
  task automatic send_cmd(input int f, input int a, input int b, input int c);
    @(posedge clk_72m);
    cmd_vld     <= 1'b1;
    cmd_foot    <= quad_servo_pkg::foot_t'(f);
    cmd_width_a <= 16'(a);
    cmd_width_b <= 16'(b);
    cmd_width_c <= 16'(c);
    @(posedge clk_72m);
    cmd_vld     <= 1'b0;                            // single cycle strobe
  endtask

  task automatic send_random(input int f);
    int a;
    int b;
    int c;
    a = int'($unsigned($random(seed)) % 100);
    b = int'($unsigned($random(seed)) % 100);
    c = int'($unsigned($random(seed)) % 100);
    send_cmd(f, a, b, c);
  endtask

  task automatic wait_frames(input int n);
    repeat (n * FRAME_CYCLES) @(posedge clk_72m);
  endtask

  task automatic play_out();
    wait (foot_busystate);
    wait (!foot_busystate);                         // last entry popped
    wait_frames(2);                                 // let it show in a full frame
  endtask

  initial
  begin
    clk_72m     = 1'b0;
    rst         = 1'b1;
    cmd_vld     = 1'b0;
    cmd_foot    = '0;
    cmd_width_a = '0;
    cmd_width_b = '0;
    cmd_width_c = '0;
    cycle_cnt   = 0;
    seed        = 32'h131a;
    repeat (3) @(posedge clk_72m);
    rst <= 1'b0;
    wait_frames(1);                                 // idle frame, all outputs low
    for (int f = 0; f < quad_servo_pkg::NUM_FEET; f++)
    begin
      send_random(f);                               // one foot at a time
      play_out();
    end
    for (int k = 0; k < 3; k++)
      send_random(1);                               // three in a row, played in order
    play_out();
    @(negedge clk_72m);
    while (cnt_m != 1)
      @(negedge clk_72m);                           // burst well inside one frame
    for (int k = 0; k < 10; k++)
      send_cmd(2, 80 + 3 * k, 25 + 5 * k, 40 + 2 * k);
    play_out();
    send_cmd(3, 0, 200, 0);                         // both clamp limits
    send_cmd(1, 200, 0, 200);
    play_out();
    if (!bp_seen)
      stop_on_error("foot_backpress never went high during the burst");
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule
